// File: rv_id_stage.f
hdl/rv_isa_pkg.sv
hdl/id_pipe_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_mux.sv
hdl/id_pc_target.sv
hdl/id_ex_pipe_reg.sv
hdl/id_stage.sv
testbench/tb_id_stage.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= rv_id_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_id_stage.sv
// Decode stage testbench

`timescale 1ns/10ps

module tb_id_stage import rv_isa_pkg::*; import id_pipe_pkg::*; ();

  localparam int NUM_TESTS   = 6;
  localparam int CLK_PERIOD  = 100;
  // Each test gets a budget of 40 clock cycles
  localparam int WATCHDOG_NS = NUM_TESTS * 40 * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  if_id_pipe_t if_id_pipe;
  byp_ctrl_t   byp;
  word_t       rf_wdata_ex;
  word_t       rf_wdata_wb;
  word_t       rf_rdata [2];
  logic        ex_ready;
  logic        kill;
  reg_addr_t   rf_raddr [2];
  logic [1:0]  rf_re;
  word_t       jmp_target;
  logic        id_ready;
  logic        id_valid;
  id_ex_pipe_t id_ex_pipe;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] rng_state = 32'h88b6_4d12;

  id_stage dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_pipe_i  (if_id_pipe),
    .byp_i         (byp),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .rf_rdata_i    (rf_rdata),
    .ex_ready_i    (ex_ready),
    .kill_i        (kill),
    .rf_raddr_o    (rf_raddr),
    .rf_re_o       (rf_re),
    .jmp_target_o  (jmp_target),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  //////////////////////////////
  // Clock and register file
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Register contents are a fixed function of the index
  function automatic word_t rf_value(reg_addr_t addr);
    return 32'(addr) * 32'h0101_0101 + 32'd7;
  endfunction

  assign rf_rdata[0] = rf_value(rf_raddr[0]);
  assign rf_rdata[1] = rf_value(rf_raddr[1]);

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Xorshift32 generator
  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t random_pc();
    word_t r;
    r = next_rand();
    return {r[31:2], 2'b00};
  endfunction

  // Random registers and immediate around a fixed opcode and funct3
  function automatic word_t with_fields(logic [6:0] opc, logic [2:0] f3);
    word_t r;
    r = next_rand();
    return {r[31:15], f3, r[11:7], opc};
  endfunction

  // Legal OP or OP-IMM instruction
  function automatic word_t random_alu_instr(logic imm);
    word_t      r;
    logic [2:0] f3;
    logic [6:0] f7;
    r  = next_rand();
    f3 = r[14:12];
    // Alternate encoding exists for SUB and for SRA/SRAI
    f7 = ((((f3 == 3'd0) && !imm) || (f3 == 3'd5)) && r[30]) ? 7'h20 : 7'h00;
    if (imm && (f3 != 3'd1) && (f3 != 3'd5)) begin
      f7 = r[31:25];
    end
    return {f7, r[24:20], r[19:15], f3, r[11:7], (imm ? 7'h13 : 7'h33)};
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic word_t imm_i_of(word_t i);
    return {{20{i[31]}}, i[31:20]};
  endfunction

  function automatic word_t imm_s_of(word_t i);
    return {{20{i[31]}}, i[31:25], i[11:7]};
  endfunction

  function automatic word_t imm_b_of(word_t i);
    return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
  endfunction

  function automatic word_t imm_j_of(word_t i);
    return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
  endfunction

  function automatic word_t fwd_value(fw_sel_e sel, word_t rf);
    if (sel == SEL_FW_EX) begin
      return rf_wdata_ex;
    end else if (sel == SEL_FW_WB) begin
      return rf_wdata_wb;
    end
    return rf;
  endfunction

  // ALU function of OP and OP-IMM
  function automatic alu_op_e expected_alu_op(logic imm, logic [2:0] f3, logic [6:0] f7);
    case (f3)
      3'd0:    return (!imm && f7[5]) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return f7[5] ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_alu_op(logic [2:0] f3);
    case (f3)
      3'd1:    return ALU_NE;
      3'd4:    return ALU_LT;
      3'd5:    return ALU_GE;
      3'd6:    return ALU_LTU;
      3'd7:    return ALU_GEU;
      default: return ALU_EQ;
    endcase
  endfunction

  function automatic lsu_size_e size_of(logic [2:0] f3);
    if (f3[1:0] == 2'b00) begin
      return LSU_BYTE;
    end else if (f3[1:0] == 2'b01) begin
      return LSU_HALF;
    end
    return LSU_WORD;
  endfunction

  // Source registers each class reads
  // Undecoded opcodes request both ports
  function automatic logic [1:0] expected_reads(word_t instr);
    case (instr[6:0])
      7'h13, 7'h03, 7'h67: return 2'b01;
      7'h37, 7'h17, 7'h6f: return 2'b00;
      default:             return 2'b11;
    endcase
  endfunction

  // Builds the expected record and flags in ops which operands A/B/C are defined
  function automatic id_ex_pipe_t model_decode(input word_t pc, input word_t instr,
                                               output logic [2:0] ops);
    id_ex_pipe_t e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    word_t       a_fw;
    word_t       b_fw;
    opc  = instr[6:0];
    f3   = instr[14:12];
    a_fw = fwd_value(byp.op_a_fw_sel, rf_value(instr[19:15]));
    b_fw = fwd_value(byp.op_b_fw_sel, rf_value(instr[24:20]));
    e          = '0;
    e.valid    = 1'b1;
    e.pc       = pc;
    e.instr    = instr;
    e.rf_waddr = instr[11:7];
    e.alu_op   = ALU_ADD;
    e.lsu_size = size_of(f3);
    ops        = 3'b011;
    case (opc)
      7'h33, 7'h13: begin
        e.alu_en    = 1'b1;
        e.rf_we     = 1'b1;
        e.operand_a = a_fw;
        e.operand_b = (opc == 7'h13) ? imm_i_of(instr) : b_fw;
        e.alu_op    = expected_alu_op(opc == 7'h13, f3, instr[31:25]);
      end
      7'h37, 7'h17: begin
        e.alu_en    = 1'b1;
        e.rf_we     = 1'b1;
        e.operand_a = (opc == 7'h37) ? 32'd0 : pc;
        e.operand_b = {instr[31:12], 12'h000};
      end
      7'h6f, 7'h67: begin
        // Link address pc + 4
        e.alu_en    = 1'b1;
        e.alu_jmp   = 1'b1;
        e.rf_we     = 1'b1;
        e.operand_a = pc;
        e.operand_b = 32'd4;
      end
      7'h63: begin
        e.alu_en    = 1'b1;
        e.alu_bch   = 1'b1;
        e.alu_op    = branch_alu_op(f3);
        e.operand_a = a_fw;
        e.operand_b = b_fw;
        e.operand_c = pc + imm_b_of(instr);
        ops         = 3'b111;
      end
      7'h03: begin
        e.lsu_en    = 1'b1;
        e.lsu_sext  = !f3[2];
        e.rf_we     = 1'b1;
        e.operand_a = a_fw;
        e.operand_b = imm_i_of(instr);
      end
      7'h23: begin
        e.lsu_en    = 1'b1;
        e.lsu_we    = 1'b1;
        e.operand_a = a_fw;
        e.operand_b = imm_s_of(instr);
        e.operand_c = b_fw;
        ops         = 3'b111;
      end
      default: begin
        e.illegal = 1'b1;
        ops       = 3'b000;
      end
    endcase
    return e;
  endfunction

  function automatic word_t expected_jump(word_t pc, word_t instr);
    word_t sum;
    if (instr[6:0] == 7'h67) begin
      sum = fwd_value(byp.jalr_fw_sel, rf_value(instr[19:15])) + imm_i_of(instr);
      return {sum[31:1], 1'b0};
    end
    return pc + imm_j_of(instr);
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(string what, reg_addr_t got, reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_alu_op(string what, alu_op_e got, alu_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_size(string what, lsu_size_e got, lsu_size_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_record(id_ex_pipe_t exp, logic [2:0] ops);
    check_bit("valid", id_ex_pipe.valid, exp.valid);
    check_word("pc", id_ex_pipe.pc, exp.pc);
    check_word("instr", id_ex_pipe.instr, exp.instr);
    check_bit("alu_en", id_ex_pipe.alu_en, exp.alu_en);
    check_bit("lsu_en", id_ex_pipe.lsu_en, exp.lsu_en);
    check_bit("rf_we", id_ex_pipe.rf_we, exp.rf_we);
    check_bit("illegal", id_ex_pipe.illegal, exp.illegal);
    // Detail fields are only defined while their unit is enabled
    if (exp.alu_en) begin
      check_bit("alu_bch", id_ex_pipe.alu_bch, exp.alu_bch);
      check_bit("alu_jmp", id_ex_pipe.alu_jmp, exp.alu_jmp);
      check_alu_op("alu_op", id_ex_pipe.alu_op, exp.alu_op);
    end
    if (exp.lsu_en) begin
      check_bit("lsu_we", id_ex_pipe.lsu_we, exp.lsu_we);
      check_size("lsu_size", id_ex_pipe.lsu_size, exp.lsu_size);
      check_bit("lsu_sext", id_ex_pipe.lsu_sext, exp.lsu_sext);
    end
    if (exp.rf_we) begin
      check_addr("rf_waddr", id_ex_pipe.rf_waddr, exp.rf_waddr);
    end
    if (ops[0]) check_word("operand_a", id_ex_pipe.operand_a, exp.operand_a);
    if (ops[1]) check_word("operand_b", id_ex_pipe.operand_b, exp.operand_b);
    if (ops[2]) check_word("operand_c", id_ex_pipe.operand_c, exp.operand_c);
  endtask

  //////////////////////////////
  // Drivers
  //////////////////////////////

  // Called on a falling edge and waits for the combinational outputs
  task automatic apply(word_t pc, word_t instr, logic valid, logic ready, logic kl);
    if_id_pipe = '{valid: valid, pc: pc, instr: instr};
    ex_ready   = ready;
    kill       = kl;
    #1;
  endtask

  // Waits for an accepting edge and then for the next falling edge
  task automatic transfer();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = id_valid && ex_ready;
    end
    @(negedge clk);
  endtask

  task automatic run_instr(word_t pc, word_t instr);
    id_ex_pipe_t exp;
    logic [2:0]  ops;
    logic [1:0]  reads;
    exp   = model_decode(pc, instr, ops);
    reads = expected_reads(instr);
    apply(pc, instr, 1'b1, 1'b1, 1'b0);
    check_bit("id_valid_o", id_valid, 1'b1);
    check_addr("rf_raddr_o[0]", rf_raddr[0], instr[19:15]);
    check_addr("rf_raddr_o[1]", rf_raddr[1], instr[24:20]);
    check_bit("rf_re_o[0]", rf_re[0], reads[0]);
    check_bit("rf_re_o[1]", rf_re[1], reads[1]);
    if ((instr[6:0] == 7'h6f) || (instr[6:0] == 7'h67)) begin
      check_word("jmp_target_o", jmp_target, expected_jump(pc, instr));
    end
    transfer();
    compare_record(exp, ops);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset();
    @(posedge clk);
    @(negedge clk);
    check_bit("valid after reset", id_ex_pipe.valid, 1'b0);
    check_bit("rf_we after reset", id_ex_pipe.rf_we, 1'b0);
    check_bit("alu_en after reset", id_ex_pipe.alu_en, 1'b0);
    check_bit("lsu_en after reset", id_ex_pipe.lsu_en, 1'b0);
    check_bit("illegal after reset", id_ex_pipe.illegal, 1'b0);
    check_word("operand_a after reset", id_ex_pipe.operand_a, '0);
    check_word("operand_b after reset", id_ex_pipe.operand_b, '0);
    check_word("operand_c after reset", id_ex_pipe.operand_c, '0);
  endtask

  task automatic test_alu_random();
    repeat (24) begin
      run_instr(random_pc(), random_alu_instr(next_rand() > 32'h8000_0000));
    end
  endtask

  task automatic test_forwarding();
    rf_wdata_ex = next_rand();
    rf_wdata_wb = next_rand();
    byp = '{SEL_FW_EX, SEL_FW_WB, SEL_REGFILE};
    run_instr(random_pc(), random_alu_instr(1'b0));
    byp = '{SEL_FW_WB, SEL_FW_EX, SEL_REGFILE};
    run_instr(random_pc(), random_alu_instr(1'b0));
    // Store data follows the B forwarding select
    byp = '{SEL_REGFILE, SEL_FW_EX, SEL_REGFILE};
    run_instr(random_pc(), with_fields(7'h23, 3'b010));
    byp = '{SEL_REGFILE, SEL_REGFILE, SEL_FW_WB};
    run_instr(random_pc(), with_fields(7'h67, 3'b000));
    byp = '{SEL_REGFILE, SEL_REGFILE, SEL_REGFILE};
  endtask

  task automatic test_jumps();
    run_instr(random_pc(), with_fields(7'h37, 3'(next_rand())));
    run_instr(random_pc(), with_fields(7'h17, 3'(next_rand())));
    run_instr(random_pc(), with_fields(7'h6f, 3'(next_rand())));
    run_instr(random_pc(), with_fields(7'h67, 3'b000));
  endtask

  task automatic test_branch_mem();
    logic [2:0] bch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0] ld_f3 [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [2:0] st_f3 [3]  = '{3'd0, 3'd1, 3'd2};
    foreach (bch_f3[i]) run_instr(random_pc(), with_fields(7'h63, bch_f3[i]));
    foreach (ld_f3[i]) run_instr(random_pc(), with_fields(7'h03, ld_f3[i]));
    foreach (st_f3[i]) run_instr(random_pc(), with_fields(7'h23, st_f3[i]));
    // Custom-0 and SYSTEM are not decoded
    run_instr(random_pc(), with_fields(7'h0b, 3'b000));
    run_instr(random_pc(), with_fields(7'h73, 3'b000));
  endtask

  task automatic test_handshake();
    id_ex_pipe_t held;
    word_t       pc;
    word_t       instr;
    run_instr(random_pc(), random_alu_instr(1'b0));
    held  = id_ex_pipe;
    pc    = random_pc();
    instr = random_alu_instr(1'b1);

    // Back-pressure from EX
    apply(pc, instr, 1'b1, 1'b0, 1'b0);
    check_bit("id_ready_o while stalled", id_ready, 1'b0);
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("id_ready_o while stalled", id_ready, 1'b0);
      check_bit("record held while stalled", id_ex_pipe == held, 1'b1);
    end

    // Kill flushes ID even while EX stalls
    apply(pc, instr, 1'b1, 1'b0, 1'b1);
    check_bit("id_ready_o with kill", id_ready, 1'b1);
    check_bit("id_valid_o with kill", id_valid, 1'b0);
    @(negedge clk);
    apply(pc, instr, 1'b1, 1'b1, 1'b1);
    @(posedge clk);
    @(negedge clk);
    check_bit("valid after kill", id_ex_pipe.valid, 1'b0);

    // Bubble from fetch
    run_instr(pc, instr);
    apply(pc, instr, 1'b0, 1'b1, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_bit("valid after bubble", id_ex_pipe.valid, 1'b0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n       = 1'b0;
    if_id_pipe  = '0;
    byp         = '{SEL_REGFILE, SEL_REGFILE, SEL_REGFILE};
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    ex_ready    = 1'b1;
    kill        = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    test_alu_random();
    test_forwarding();
    test_jumps();
    test_branch_mem();
    test_handshake();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: hdl/id_stage.sv
// RV32I instruction decode stage

`timescale 1ns/10ps

module id_stage import rv_isa_pkg::*; import id_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  if_id_pipe_t if_id_pipe_i,
  input  byp_ctrl_t   byp_i,
  input  word_t       rf_wdata_ex_i,
  input  word_t       rf_wdata_wb_i,
  input  word_t       rf_rdata_i [2],
  input  logic        ex_ready_i,
  input  logic        kill_i,
  output reg_addr_t   rf_raddr_o [2],
  output logic [1:0]  rf_re_o,
  output word_t       jmp_target_o,
  output logic        id_ready_o,
  output logic        id_valid_o,
  output id_ex_pipe_t id_ex_pipe_o
);

  // Decoded control
  logic       alu_en;
  logic       alu_bch;
  logic       alu_jmp;
  alu_op_e    alu_op;
  logic       lsu_en;
  logic       lsu_we;
  lsu_size_e  lsu_size;
  logic       lsu_sext;
  logic       rf_we;
  logic       illegal;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  op_c_sel_e  op_c_sel;
  imm_b_sel_e imm_b_sel;
  jmp_sel_e   jmp_sel;

  // Datapath
  word_t      operand_a;
  word_t      operand_b;
  word_t      operand_c;
  word_t      jalr_base;
  word_t      bch_target;
  reg_addr_t  rf_waddr;

  //////////////////////////////
  // Register fields
  //////////////////////////////

  assign rf_raddr_o[0] = if_id_pipe_i.instr[REG_S1_LSB +: $bits(reg_addr_t)];
  assign rf_raddr_o[1] = if_id_pipe_i.instr[REG_S2_LSB +: $bits(reg_addr_t)];
  assign rf_waddr      = if_id_pipe_i.instr[REG_D_LSB +: $bits(reg_addr_t)];

  id_decoder u_decoder (
    .instr_i     (if_id_pipe_i.instr),
    .alu_en_o    (alu_en),
    .alu_bch_o   (alu_bch),
    .alu_jmp_o   (alu_jmp),
    .alu_op_o    (alu_op),
    .lsu_en_o    (lsu_en),
    .lsu_we_o    (lsu_we),
    .lsu_size_o  (lsu_size),
    .lsu_sext_o  (lsu_sext),
    .rf_re_o     (rf_re_o),
    .rf_we_o     (rf_we),
    .illegal_o   (illegal),
    .op_a_sel_o  (op_a_sel),
    .op_b_sel_o  (op_b_sel),
    .op_c_sel_o  (op_c_sel),
    .imm_b_sel_o (imm_b_sel),
    .jmp_sel_o   (jmp_sel)
  );

  id_operand_mux u_operand_mux (
    .pc_i          (if_id_pipe_i.pc),
    .instr_i       (if_id_pipe_i.instr),
    .rf_rdata_i    (rf_rdata_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .bch_target_i  (bch_target),
    .byp_i         (byp_i),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .op_c_sel_i    (op_c_sel),
    .imm_b_sel_i   (imm_b_sel),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jalr_base_o   (jalr_base)
  );

  // Jump target goes straight back to fetch
  id_pc_target u_pc_target (
    .pc_i         (if_id_pipe_i.pc),
    .instr_i      (if_id_pipe_i.instr),
    .jalr_base_i  (jalr_base),
    .jmp_sel_i    (jmp_sel),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_pipe_reg u_pipe_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_pipe_i (if_id_pipe_i),
    .alu_en_i     (alu_en),
    .alu_bch_i    (alu_bch),
    .alu_jmp_i    (alu_jmp),
    .alu_op_i     (alu_op),
    .op_a_sel_i   (op_a_sel),
    .op_b_sel_i   (op_b_sel),
    .op_c_sel_i   (op_c_sel),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .operand_c_i  (operand_c),
    .lsu_en_i     (lsu_en),
    .lsu_we_i     (lsu_we),
    .lsu_size_i   (lsu_size),
    .lsu_sext_i   (lsu_sext),
    .rf_we_i      (rf_we),
    .rf_waddr_i   (rf_waddr),
    .illegal_i    (illegal),
    .kill_i       (kill_i),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (id_valid_o),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

// File: hdl/id_ex_pipe_reg.sv
// ID/EX pipeline register

`timescale 1ns/10ps

module id_ex_pipe_reg import rv_isa_pkg::*; import id_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  if_id_pipe_t if_id_pipe_i,
  input  logic        alu_en_i,
  input  logic        alu_bch_i,
  input  logic        alu_jmp_i,
  input  alu_op_e     alu_op_i,
  input  op_a_sel_e   op_a_sel_i,
  input  op_b_sel_e   op_b_sel_i,
  input  op_c_sel_e   op_c_sel_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  input  word_t       operand_c_i,
  input  logic        lsu_en_i,
  input  logic        lsu_we_i,
  input  lsu_size_e   lsu_size_i,
  input  logic        lsu_sext_i,
  input  logic        rf_we_i,
  input  reg_addr_t   rf_waddr_i,
  input  logic        illegal_i,
  input  logic        kill_i,
  input  logic        ex_ready_i,
  output logic        id_ready_o,
  output logic        id_valid_o,
  output id_ex_pipe_t id_ex_pipe_o
);

  //////////////////////////////
  // Stage handshake
  //////////////////////////////

  // A killed instruction is dropped, so ID can always accept then
  assign id_valid_o = if_id_pipe_i.valid && !kill_i;
  assign id_ready_o = ex_ready_i || kill_i;

  //////////////////////////////
  // Record register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_pipe_o <= '0;
    end else if (id_valid_o && ex_ready_i) begin
      id_ex_pipe_o.valid   <= 1'b1;
      id_ex_pipe_o.pc      <= if_id_pipe_i.pc;
      id_ex_pipe_o.instr   <= if_id_pipe_i.instr;
      id_ex_pipe_o.illegal <= illegal_i;

      // Operands only load when their mux is in use
      if (op_a_sel_i != OP_A_NONE) begin
        id_ex_pipe_o.operand_a <= operand_a_i;
      end
      if (op_b_sel_i != OP_B_NONE) begin
        id_ex_pipe_o.operand_b <= operand_b_i;
      end
      if (op_c_sel_i != OP_C_NONE) begin
        id_ex_pipe_o.operand_c <= operand_c_i;
      end

      // ALU details follow the unit enable
      id_ex_pipe_o.alu_en <= alu_en_i;
      if (alu_en_i) begin
        id_ex_pipe_o.alu_bch <= alu_bch_i;
        id_ex_pipe_o.alu_jmp <= alu_jmp_i;
        id_ex_pipe_o.alu_op  <= alu_op_i;
      end

      // LSU details likewise
      id_ex_pipe_o.lsu_en <= lsu_en_i;
      if (lsu_en_i) begin
        id_ex_pipe_o.lsu_we   <= lsu_we_i;
        id_ex_pipe_o.lsu_size <= lsu_size_i;
        id_ex_pipe_o.lsu_sext <= lsu_sext_i;
      end

      id_ex_pipe_o.rf_we <= rf_we_i;
      if (rf_we_i) begin
        id_ex_pipe_o.rf_waddr <= rf_waddr_i;
      end
    end else if (ex_ready_i) begin
      // EX consumed its record, nothing new arrives
      id_ex_pipe_o.valid <= 1'b0;
    end
  end

endmodule

// File: hdl/id_pc_target.sv
// Branch and jump target adders

`timescale 1ns/10ps

module id_pc_target import rv_isa_pkg::*; import id_pipe_pkg::*; (
  input  word_t    pc_i,
  input  word_t    instr_i,
  input  word_t    jalr_base_i,
  input  jmp_sel_e jmp_sel_i,
  output word_t    bch_target_o,
  output word_t    jmp_target_o
);

  word_t imm_i;
  word_t imm_sb;
  word_t imm_uj;
  word_t jalr_sum;

  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_uj = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

  // Branch target, resolved later in EX
  assign bch_target_o = pc_i + imm_sb;

  // JALR clears the lowest bit of the sum
  assign jalr_sum     = jalr_base_i + imm_i;
  assign jmp_target_o = (jmp_sel_i == JMP_JALR) ? {jalr_sum[31:1], 1'b0} : pc_i + imm_uj;

endmodule

// File: hdl/id_operand_mux.sv
// Operand selection and forwarding

`timescale 1ns/10ps

module id_operand_mux import rv_isa_pkg::*; import id_pipe_pkg::*; (
  input  word_t      pc_i,
  input  word_t      instr_i,
  input  word_t      rf_rdata_i [2],
  input  word_t      rf_wdata_ex_i,
  input  word_t      rf_wdata_wb_i,
  input  word_t      bch_target_i,
  input  byp_ctrl_t  byp_i,
  input  op_a_sel_e  op_a_sel_i,
  input  op_b_sel_e  op_b_sel_i,
  input  op_c_sel_e  op_c_sel_i,
  input  imm_b_sel_e imm_b_sel_i,
  output word_t      operand_a_o,
  output word_t      operand_b_o,
  output word_t      operand_c_o,
  output word_t      jalr_base_o
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm_b;
  word_t operand_a_fw;
  word_t operand_b_fw;

  // One forwarding mux, shared by A, B and the JALR base
  function automatic word_t fw_mux(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
    word_t res;
    unique case (sel)
      SEL_FW_EX: res = ex;
      SEL_FW_WB: res = wb;
      default:   res = rf;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Immediates
  //////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'h000};

  always_comb begin
    unique case (imm_b_sel_i)
      IMMB_S:      imm_b = imm_s;
      IMMB_U:      imm_b = imm_u;
      // Link address offset
      IMMB_PCINCR: imm_b = 32'd4;
      default:     imm_b = imm_i;
    endcase
  end

  //////////////////////////////
  // Forwarding
  //////////////////////////////

  assign operand_a_fw = fw_mux(byp_i.op_a_fw_sel, rf_rdata_i[0], rf_wdata_ex_i, rf_wdata_wb_i);
  assign operand_b_fw = fw_mux(byp_i.op_b_fw_sel, rf_rdata_i[1], rf_wdata_ex_i, rf_wdata_wb_i);
  assign jalr_base_o  = fw_mux(byp_i.jalr_fw_sel, rf_rdata_i[0], rf_wdata_ex_i, rf_wdata_wb_i);

  //////////////////////////////
  // Operand selection
  //////////////////////////////

  always_comb begin
    unique case (op_a_sel_i)
      OP_A_CURRPC: operand_a_o = pc_i;
      // Zero immediate, LUI adds onto it
      OP_A_IMM:    operand_a_o = '0;
      default:     operand_a_o = operand_a_fw;
    endcase
  end

  assign operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : operand_b_fw;

  // Store data or branch target
  assign operand_c_o = (op_c_sel_i == OP_C_BCH) ? bch_target_i : operand_b_fw;

endmodule

// File: hdl/id_decoder.sv
// RV32I instruction decoder

`timescale 1ns/10ps

module id_decoder import rv_isa_pkg::*; import id_pipe_pkg::*; (
  input  word_t      instr_i,
  output logic       alu_en_o,
  output logic       alu_bch_o,
  output logic       alu_jmp_o,
  output alu_op_e    alu_op_o,
  output logic       lsu_en_o,
  output logic       lsu_we_o,
  output lsu_size_e  lsu_size_o,
  output logic       lsu_sext_o,
  output logic [1:0] rf_re_o,
  output logic       rf_we_o,
  output logic       illegal_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output op_c_sel_e  op_c_sel_o,
  output imm_b_sel_e imm_b_sel_o,
  output jmp_sel_e   jmp_sel_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  // SLLI, SRLI and SRAI carry funct7 in the immediate field
  assign shift  = (funct3[1:0] == 2'b01);

  always_comb begin
    // Defaults describe a bubble
    alu_en_o    = 1'b0;
    alu_bch_o   = 1'b0;
    alu_jmp_o   = 1'b0;
    alu_op_o    = ALU_ADD;
    lsu_en_o    = 1'b0;
    lsu_we_o    = 1'b0;
    lsu_size_o  = LSU_WORD;
    lsu_sext_o  = 1'b0;
    rf_re_o     = 2'b00;
    rf_we_o     = 1'b0;
    illegal_o   = 1'b0;
    op_a_sel_o  = OP_A_NONE;
    op_b_sel_o  = OP_B_NONE;
    op_c_sel_o  = OP_C_NONE;
    imm_b_sel_o = IMMB_I;
    jmp_sel_o   = JMP_JAL;

    unique case (opcode)
      OPC_OP: begin
        alu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        rf_re_o    = 2'b11;
        op_a_sel_o = OP_A_REG_OR_FWD;
        op_b_sel_o = OP_B_REG_OR_FWD;
        alu_op_o   = alu_op_e'({1'b0, funct7[5], funct3});
        // Only SUB and SRA use the alternate funct7
        illegal_o  = !((funct7 == 7'h00) ||
                       ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      OPC_OP_IMM: begin
        alu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        rf_re_o    = 2'b01;
        op_a_sel_o = OP_A_REG_OR_FWD;
        op_b_sel_o = OP_B_IMM;
        alu_op_o   = alu_op_e'({1'b0, shift && funct7[5], funct3});
        illegal_o  = shift && !((funct7 == 7'h00) || ((funct7 == 7'h20) && funct3[2]));
      end
      OPC_LUI, OPC_AUIPC: begin
        // Upper immediate added to zero or to the PC
        alu_en_o    = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = (opcode == OPC_LUI) ? OP_A_IMM : OP_A_CURRPC;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_U;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value is PC + 4, computed in the ALU
        alu_en_o    = 1'b1;
        alu_jmp_o   = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_PCINCR;
        if (opcode == OPC_JALR) begin
          jmp_sel_o = JMP_JALR;
          rf_re_o   = 2'b01;
          illegal_o = (funct3 != 3'b000);
        end
      end
      OPC_BRANCH: begin
        alu_en_o   = 1'b1;
        alu_bch_o  = 1'b1;
        rf_re_o    = 2'b11;
        op_a_sel_o = OP_A_REG_OR_FWD;
        op_b_sel_o = OP_B_REG_OR_FWD;
        op_c_sel_o = OP_C_BCH;
        alu_op_o   = alu_op_e'({2'b10, funct3});
        illegal_o  = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        lsu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        rf_re_o    = 2'b01;
        op_a_sel_o = OP_A_REG_OR_FWD;
        op_b_sel_o = OP_B_IMM;
        lsu_size_o = lsu_size_e'(funct3[1:0]);
        lsu_sext_o = !funct3[2];
        illegal_o  = (funct3[1:0] == 2'b11) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        // Store data travels in operand C
        lsu_en_o    = 1'b1;
        lsu_we_o    = 1'b1;
        rf_re_o     = 2'b11;
        op_a_sel_o  = OP_A_REG_OR_FWD;
        op_b_sel_o  = OP_B_IMM;
        op_c_sel_o  = OP_C_REG_OR_FWD;
        imm_b_sel_o = IMMB_S;
        lsu_size_o  = lsu_size_e'(funct3[1:0]);
        illegal_o   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal_o = 1'b1;
    endcase

    // Illegal instructions enable nothing but read both sources speculatively
    if (illegal_o) begin
      alu_en_o  = 1'b0;
      alu_bch_o = 1'b0;
      alu_jmp_o = 1'b0;
      lsu_en_o  = 1'b0;
      lsu_we_o  = 1'b0;
      rf_we_o   = 1'b0;
      rf_re_o   = 2'b11;
    end
  end

endmodule

// File: hdl/id_pipe_pkg.sv
// Decode stage selects and pipeline records

package id_pipe_pkg;

  import rv_isa_pkg::*;

  // ALU functions, low nibble follows {funct7[5], funct3}
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    // Branch compares, low bits follow funct3
    ALU_EQ   = 5'b10000,
    ALU_NE   = 5'b10001,
    ALU_LT   = 5'b10100,
    ALU_GE   = 5'b10101,
    ALU_LTU  = 5'b10110,
    ALU_GEU  = 5'b10111
  } alu_op_e;

  // Access size, matches funct3[1:0]
  typedef enum logic [1:0] {LSU_BYTE = 2'b00, LSU_HALF = 2'b01, LSU_WORD = 2'b10} lsu_size_e;

  //////////////////////////////
  // Operand mux selects
  //////////////////////////////

  typedef enum logic [1:0] {OP_A_REG_OR_FWD, OP_A_CURRPC, OP_A_IMM, OP_A_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG_OR_FWD, OP_B_IMM, OP_B_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REG_OR_FWD, OP_C_BCH, OP_C_NONE} op_c_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;
  typedef enum logic {JMP_JAL, JMP_JALR} jmp_sel_e;

  //////////////////////////////
  // Pipeline records
  //////////////////////////////

  // From fetch
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  // Forwarding selects from the controller
  typedef struct packed {
    fw_sel_e op_a_fw_sel;
    fw_sel_e op_b_fw_sel;
    fw_sel_e jalr_fw_sel;
  } byp_ctrl_t;

  // To execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     instr;
    logic      alu_en;
    logic      alu_bch;
    logic      alu_jmp;
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     operand_c;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sext;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      illegal;
  } id_ex_pipe_t;

endpackage

// File: hdl/rv_isa_pkg.sv
// RV32I ISA encoding definitions

package rv_isa_pkg;

  //////////////////////////////
  // Basic word types
  //////////////////////////////

  // Data and address word
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0]  reg_addr_t;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  // Only the base integer classes are decoded, anything else is illegal
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  //////////////////////////////
  // Register field positions
  //////////////////////////////

  // LSB of rs1, rs2 and rd inside the instruction word
  localparam int unsigned REG_S1_LSB = 15;
  localparam int unsigned REG_S2_LSB = 20;
  localparam int unsigned REG_D_LSB  = 7;

endpackage
